// ==== filelist.f ====
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_ctrl.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/mips_datapath.sv
rtl/mips_pipe.sv
bench/mips_pipe_chk.sv
bench/tb_mips_pipe.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MIPS pipeline simulation with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_mips_pipe -o sim_mips
./obj_dir/sim_mips

// ==== bench/tb_mips_pipe.sv ====
/*
 * Testbench for the pipelined MIPS core
 * Random program, memory models, instruction-set model and checks
 */
`timescale 1ns/100ps
`include "mips_defs.svh"

module tb_mips_pipe;
  import mips_pkg::*;

  localparam int NCYC = 400;
  localparam int SUB_W = 250;

  logic        clk;
  logic        rst_n;
  logic [31:0] pc_f, instr_f, aluout_m, writedata_m, readdata_m, pc_off;
  logic        memwrite_m;

  logic [31:0] prog [256];
  logic [31:0] dmem [64];
  logic [31:0] dm_init [64];
  logic [31:0] fetch [NCYC];
  logic [31:0] st_addr [$];
  logic [31:0] st_data [$];
  int          st_cyc [$];
  int          seed;
  int          st_idx;
  int          cyc;

  mips_pipe u_mips_pipe (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc_f        (pc_f),
    .instr_f     (instr_f),
    .memwrite_m  (memwrite_m),
    .aluout_m    (aluout_m),
    .writedata_m (writedata_m),
    .readdata_m  (readdata_m)
  );

  // ----------------------------------------
  // Memory models
  // ----------------------------------------
  assign pc_off     = pc_f - `MIPS_RESET_PC;
  assign instr_f    = prog[pc_off[9:2]];
  assign readdata_m = dmem[aluout_m[7:2]];

  always @(posedge clk) begin
    if (rst_n && memwrite_m)
      dmem[aluout_m[7:2]] <= writedata_m;
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // ----------------------------------------
  // Program generator
  // ----------------------------------------
  function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] fn);
    mips_instr_u w;
    w = '0;
    w.r_fmt.op = `MIPS_OP_RTYPE;
    w.r_fmt.rs = rs;
    w.r_fmt.rt = rt;
    w.r_fmt.rd = rd;
    w.r_fmt.funct = fn;
    return w;
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    mips_instr_u w;
    w.i_fmt.op = op;
    w.i_fmt.rs = rs;
    w.i_fmt.rt = rt;
    w.i_fmt.imm = imm;
    return w;
  endfunction

  function automatic logic [31:0] enc_j(input logic [5:0] op, input int word);
    mips_instr_u w;
    logic [31:0] addr;
    addr = `MIPS_RESET_PC + 32'(word * 4);
    w.j_fmt.op = op;
    w.j_fmt.target = addr[27:2];
    return w;
  endfunction

  // Source not written by the last two, r0 as the fallback
  function automatic logic [4:0] pick_src(input logic [4:0] w1, input logic [4:0] w2);
    logic [4:0] r;
    r = 5'({$random(seed)} % 31);
    if (r == w1 || r == w2)
      r = 5'd0;
    return r;
  endfunction

  task automatic build_program();
    logic [5:0] fn_tab [5];
    logic [4:0] w1, w2, wr, d, s1, s2;
    logic       delay;
    int         op, tgt;
    fn_tab = '{`MIPS_FN_ADD, `MIPS_FN_SUB, `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_SLT};
    for (int i = 0; i < 256; i++)
      prog[i] = '0;
    // Prologue gives r1..r30 known values
    for (int i = 1; i <= 30; i++)
      prog[i-1] = enc_i(`MIPS_OP_ADDI, 5'd0, 5'(i), 16'($random(seed)));
    w1 = 5'd30;
    w2 = 5'd29;
    delay = 1'b0;
    for (int i = 30; i < 248; i++) begin
      s1 = pick_src(w1, w2);
      s2 = pick_src(w1, w2);
      d  = 5'(1 + {$random(seed)} % 30);
      op = {$random(seed)} % 11;
      wr = 5'd0;
      // Delay slots hold a store or a nop
      if (delay)
        op = (op < 6) ? 7 : 11;
      else if (op >= 8 && i > 244)
        op = 0;
      case (op)
        0, 1, 2, 3, 4: begin
          prog[i] = enc_r(s1, s2, d, fn_tab[op]);
          wr = d;
        end
        5: begin
          prog[i] = enc_i(`MIPS_OP_ADDI, s1, d, 16'($random(seed)));
          wr = d;
        end
        6: begin
          prog[i] = enc_i(`MIPS_OP_LW, 5'd0, d, 16'(({$random(seed)} % 64) * 4));
          wr = d;
        end
        7: prog[i] = enc_i(`MIPS_OP_SW, 5'd0, s2, 16'(({$random(seed)} % 64) * 4));
        8: begin
          tgt = i + 2 + {$random(seed)} % 7;
          if (tgt > 248)
            tgt = 248;
          if ($random(seed) & 1)
            s2 = s1;
          prog[i] = enc_i(`MIPS_OP_BEQ, s1, s2, 16'(tgt - i - 1));
        end
        9: begin
          tgt = i + 2 + {$random(seed)} % 7;
          if (tgt > 248)
            tgt = 248;
          prog[i] = enc_j(`MIPS_OP_J, tgt);
        end
        10: prog[i] = enc_j(`MIPS_OP_JAL, SUB_W);
        default: prog[i] = '0;
      endcase
      delay = (op >= 8 && op <= 10);
      w2 = w1;
      w1 = wr;
    end
    prog[248] = enc_j(`MIPS_OP_J, 248);
    // Subroutine stores its own return address
    prog[SUB_W + 1] = enc_i(`MIPS_OP_SW, 5'd0, `MIPS_LINK_REG, 16'd252);
    prog[SUB_W + 3] = enc_r(`MIPS_LINK_REG, 5'd0, 5'd0, `MIPS_FN_JR);
  endtask

  // ----------------------------------------
  // Instruction-set model with delay slots
  // ----------------------------------------
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] dm [64];
    logic [31:0] pc, npc, nn, off, simm, a, b, addr;
    mips_instr_u w;
    for (int r = 0; r < 32; r++)
      regs[r] = '0;
    dm = dm_init;
    pc  = `MIPS_RESET_PC;
    npc = pc + 32'd4;
    for (int n = 0; n < NCYC; n++) begin
      fetch[n] = pc;
      off  = pc - `MIPS_RESET_PC;
      w    = prog[off[9:2]];
      simm = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
      a    = regs[w.r_fmt.rs];
      b    = regs[w.r_fmt.rt];
      addr = a + simm;
      nn   = npc + 32'd4;
      case (w.r_fmt.op)
        `MIPS_OP_RTYPE: begin
          case (w.r_fmt.funct)
            `MIPS_FN_ADD: regs[w.r_fmt.rd] = a + b;
            `MIPS_FN_SUB: regs[w.r_fmt.rd] = a - b;
            `MIPS_FN_AND: regs[w.r_fmt.rd] = a & b;
            `MIPS_FN_OR:  regs[w.r_fmt.rd] = a | b;
            `MIPS_FN_SLT: regs[w.r_fmt.rd] = {31'd0, $signed(a) < $signed(b)};
            `MIPS_FN_JR:  nn = a;
            default: ;
          endcase
        end
        `MIPS_OP_ADDI: regs[w.i_fmt.rt] = addr;
        `MIPS_OP_LW:   regs[w.i_fmt.rt] = dm[addr[7:2]];
        `MIPS_OP_SW: begin
          dm[addr[7:2]] = b;
          if (n + 3 < NCYC) begin
            st_addr.push_back(addr);
            st_data.push_back(b);
            st_cyc.push_back(n + 3);
          end
        end
        `MIPS_OP_BEQ: if (a == b) nn = npc + {simm[29:0], 2'b00};
        `MIPS_OP_J:   nn = {npc[31:28], w.j_fmt.target, 2'b00};
        `MIPS_OP_JAL: begin
          nn = {npc[31:28], w.j_fmt.target, 2'b00};
          regs[`MIPS_LINK_REG] = pc + 32'd8;
        end
        default: ;
      endcase
      regs[0] = '0;
      pc  = npc;
      npc = nn;
    end
  endtask

  task automatic check_store();
    if (memwrite_m) begin
      if (st_idx >= st_cyc.size()) begin
        $display("Store seen where the model has none, t=%0t", $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "extra store");
      end
      check("store_cycle", 32'(cyc), 32'(st_cyc[st_idx]));
      check("aluout_m", aluout_m, st_addr[st_idx]);
      check("writedata_m", writedata_m, st_data[st_idx]);
      st_idx++;
    end
  endtask

  initial begin
    seed   = 39;
    rst_n  = 1'b0;
    st_idx = 0;
    for (int a = 0; a < 64; a++) begin
      dm_init[a] = $random(seed);
      dmem[a]    = dm_init[a];
    end
    build_program();
    run_model();
    // Reset held for two cycles
    for (int k = 0; k < 2; k++) begin
      @(negedge clk);
      check("pc_f", pc_f, `MIPS_RESET_PC);
      check("memwrite_m", {31'd0, memwrite_m}, 32'd0);
    end
    rst_n = 1'b1;
    cyc = 0;
    check("pc_f", pc_f, fetch[0]);
    check("memwrite_m", {31'd0, memwrite_m}, 32'd0);
    for (cyc = 1; cyc < NCYC; cyc++) begin
      @(negedge clk);
      check("pc_f", pc_f, fetch[cyc]);
      check_store();
    end
    // Every store the model expects falls inside the run
    check("store_count", 32'(st_idx), 32'(st_cyc.size()));
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== bench/mips_pipe_chk.sv ====
/*
 * Datapath assertions
 * PC alignment, known store strobe, sequential PC flow
 */
`timescale 1ns/100ps

module mips_pipe_chk (
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] pc_f,
  input logic        memwrite_m,
  input logic        jump_d,
  input logic        pcsrc_d
);

  // Fetch address stays on word boundaries
  a_pc_align: assert property (@(posedge clk) disable iff (!rst_n)
    pc_f[1:0] == 2'b00)
    else $error("pc_f misaligned");

  a_mw_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(memwrite_m))
    else $error("memwrite_m unknown");

  // No redirect in decode, so plain increment
  a_pc_seq: assert property (@(posedge clk) disable iff (!rst_n)
    !(jump_d || pcsrc_d) |=> pc_f == $past(pc_f) + 32'd4)
    else $error("pc_f not sequential");

endmodule

bind mips_datapath mips_pipe_chk u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .pc_f       (pc_f),
  .memwrite_m (memwrite_m),
  .jump_d     (jump_d),
  .pcsrc_d    (pcsrc_d)
);

// ==== rtl/mips_pipe.sv ====
/*
 * MIPS pipelined core top level
 * Controller and datapath, memories outside
 */
`timescale 1ns/100ps

module mips_pipe (
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] pc_f,
  input  logic [31:0] instr_f,
  output logic        memwrite_m,
  output logic [31:0] aluout_m,
  output logic [31:0] writedata_m,
  input  logic [31:0] readdata_m
);
  import mips_pkg::*;

  // Decode-stage word and its control levels
  mips_instr_u instr_d;
  logic        memtoreg_d, memwrite_d, alusrc_d, regdst_d, regwrite_d;
  logic        branch_d, jump_d, jal_d, jr_d;
  alu_ctrl_e   alucontrol_d;

  mips_ctrl u_ctrl (
    .instr_d      (instr_d),
    .memtoreg_d   (memtoreg_d),
    .memwrite_d   (memwrite_d),
    .alusrc_d     (alusrc_d),
    .regdst_d     (regdst_d),
    .regwrite_d   (regwrite_d),
    .branch_d     (branch_d),
    .jump_d       (jump_d),
    .jal_d        (jal_d),
    .jr_d         (jr_d),
    .alucontrol_d (alucontrol_d)
  );

  mips_datapath u_dp (
    .clk          (clk),
    .rst_n        (rst_n),
    .memtoreg_d   (memtoreg_d),
    .memwrite_d   (memwrite_d),
    .alusrc_d     (alusrc_d),
    .regdst_d     (regdst_d),
    .regwrite_d   (regwrite_d),
    .branch_d     (branch_d),
    .jump_d       (jump_d),
    .jal_d        (jal_d),
    .jr_d         (jr_d),
    .alucontrol_d (alucontrol_d),
    .instr_d      (instr_d),
    .pc_f         (pc_f),
    .instr_f      (instr_f),
    .memwrite_m   (memwrite_m),
    .aluout_m     (aluout_m),
    .writedata_m  (writedata_m),
    .readdata_m   (readdata_m)
  );

endmodule

// ==== rtl/mips_datapath.sv ====
/*
 * MIPS five-stage datapath
 * PC, pipeline registers, decode-stage redirect and writeback select
 */
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_datapath (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  memtoreg_d,
  input  logic                  memwrite_d,
  input  logic                  alusrc_d,
  input  logic                  regdst_d,
  input  logic                  regwrite_d,
  input  logic                  branch_d,
  input  logic                  jump_d,
  input  logic                  jal_d,
  input  logic                  jr_d,
  input  mips_pkg::alu_ctrl_e   alucontrol_d,
  output mips_pkg::mips_instr_u instr_d,
  output logic [31:0]           pc_f,
  input  logic [31:0]           instr_f,
  output logic                  memwrite_m,
  output logic [31:0]           aluout_m,
  output logic [31:0]           writedata_m,
  input  logic [31:0]           readdata_m
);
  import mips_pkg::*;

  // Fetch and decode
  logic [31:0] pcplus4_f, pcnext_f;
  logic [31:0] pc_d, pcplus4_d, pcbranch_d, pcjump_d;
  logic [31:0] rd1_d, rd2_d, signimm_d;
  logic        pcsrc_d;
  // Execute
  logic        memtoreg_e, memwrite_e, alusrc_e, regdst_e, regwrite_e, jal_e;
  alu_ctrl_e   alucontrol_e;
  logic [4:0]  rt_e, rd_e, writereg_e;
  logic [31:0] rd1_e, rd2_e, signimm_e, link_e, srcb_e, aluout_e;
  // Memory
  logic        memtoreg_m, regwrite_m, jal_m;
  logic [4:0]  writereg_m;
  logic [31:0] link_m;
  // Writeback
  logic        memtoreg_w, regwrite_w, jal_w;
  logic [4:0]  writereg_w;
  logic [31:0] aluout_w, readdata_w, link_w, result_w;

  // -------------------------------------
  // Fetch and next PC
  // -------------------------------------
  assign pcplus4_f = pc_f + 32'd4;

  // Jump beats branch, jr takes rs
  assign pcnext_f = jump_d  ? (jr_d ? rd1_d : pcjump_d) :
                    pcsrc_d ? pcbranch_d : pcplus4_f;

  // -------------------------------------
  // Decode
  // -------------------------------------
  mips_regfile u_rf (
    .clk (clk),
    .we  (regwrite_w),
    .ra1 (instr_d.r_fmt.rs),
    .ra2 (instr_d.r_fmt.rt),
    .wa  (writereg_w),
    .wd  (result_w),
    .rd1 (rd1_d),
    .rd2 (rd2_d)
  );

  assign pcplus4_d = pc_d + 32'd4;
  assign signimm_d = {{16{instr_d.i_fmt.imm[15]}}, instr_d.i_fmt.imm};
  // Branch and jump targets relative to the delay slot
  assign pcbranch_d = pcplus4_d + {signimm_d[29:0], 2'b00};
  assign pcjump_d   = {pcplus4_d[31:28], instr_d.j_fmt.target, 2'b00};
  // Taken beq, compare on raw register values
  assign pcsrc_d    = branch_d && (rd1_d == rd2_d);

  // -------------------------------------
  // Execute
  // -------------------------------------
  assign srcb_e = alusrc_e ? signimm_e : rd2_e;

  mips_alu u_alu (
    .a (rd1_e),
    .b (srcb_e),
    .f (alucontrol_e),
    .y (aluout_e)
  );

  // Destination among rt, rd and r31
  assign writereg_e = jal_e    ? `MIPS_LINK_REG :
                      regdst_e ? rd_e : rt_e;

  // -------------------------------------
  // Writeback select
  // -------------------------------------
  assign result_w = jal_w      ? link_w     :
                    memtoreg_w ? readdata_w : aluout_w;

  // PC and control bits, bubbles out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_f         <= `MIPS_RESET_PC;
      instr_d      <= '0;
      memtoreg_e   <= 1'b0;
      memwrite_e   <= 1'b0;
      alusrc_e     <= 1'b0;
      regdst_e     <= 1'b0;
      regwrite_e   <= 1'b0;
      jal_e        <= 1'b0;
      alucontrol_e <= ALU_ADD;
      memtoreg_m   <= 1'b0;
      memwrite_m   <= 1'b0;
      regwrite_m   <= 1'b0;
      jal_m        <= 1'b0;
      memtoreg_w   <= 1'b0;
      regwrite_w   <= 1'b0;
      jal_w        <= 1'b0;
    end else begin
      pc_f         <= pcnext_f;
      instr_d      <= instr_f;
      memtoreg_e   <= memtoreg_d;
      memwrite_e   <= memwrite_d;
      alusrc_e     <= alusrc_d;
      regdst_e     <= regdst_d;
      regwrite_e   <= regwrite_d;
      jal_e        <= jal_d;
      alucontrol_e <= alucontrol_d;
      memtoreg_m   <= memtoreg_e;
      memwrite_m   <= memwrite_e;
      regwrite_m   <= regwrite_e;
      jal_m        <= jal_e;
      memtoreg_w   <= memtoreg_m;
      regwrite_w   <= regwrite_m;
      jal_w        <= jal_m;
    end
  end

  // Payload, qualified by the control bits above
  always_ff @(posedge clk) begin
    pc_d        <= pc_f;
    rd1_e       <= rd1_d;
    rd2_e       <= rd2_d;
    rt_e        <= instr_d.r_fmt.rt;
    rd_e        <= instr_d.r_fmt.rd;
    signimm_e   <= signimm_d;
    // Return address skips the delay slot
    link_e      <= pc_d + 32'd8;
    aluout_m    <= aluout_e;
    writedata_m <= rd2_e;
    writereg_m  <= writereg_e;
    link_m      <= link_e;
    aluout_w    <= aluout_m;
    readdata_w  <= readdata_m;
    writereg_w  <= writereg_m;
    link_w      <= link_m;
  end

endmodule

// ==== rtl/mips_alu.sv ====
/*
 * MIPS ALU
 * add, sub, and, or and signed slt on 32-bit operands
 */
`timescale 1ns/100ps

module mips_alu (
  input  logic [31:0]         a,
  input  logic [31:0]         b,
  input  mips_pkg::alu_ctrl_e f,
  output logic [31:0]         y
);
  import mips_pkg::*;

  always_comb begin
    case (f)
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_ADD: y = a + b;
      ALU_SUB: y = a - b;
      // Signed compare, result in bit 0
      ALU_SLT: y = {31'd0, $signed(a) < $signed(b)};
      default: y = a + b;
    endcase
  end

endmodule

// ==== rtl/mips_regfile.sv ====
/*
 * MIPS register file
 * Two read ports, one write port, r0 tied to zero
 */
`timescale 1ns/100ps

module mips_regfile (
  input  logic        clk,
  input  logic        we,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  input  logic [4:0]  wa,
  input  logic [31:0] wd,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] rf [32];

  // Writes land on the rising edge
  always_ff @(posedge clk) begin
    if (we && wa != 5'd0)
      rf[wa] <= wd;
  end

  // r0 first, then same-cycle bypass from writeback
  assign rd1 = (ra1 == 5'd0)            ? 32'd0 :
               (we && wa == ra1)        ? wd    : rf[ra1];
  assign rd2 = (ra2 == 5'd0)            ? 32'd0 :
               (we && wa == ra2)        ? wd    : rf[ra2];

endmodule

// ==== rtl/mips_ctrl.sv ====
/*
 * MIPS controller
 * Main and ALU decoder, decode-stage control levels
 */
`timescale 1ns/100ps
`include "mips_defs.svh"

module mips_ctrl (
  input  mips_pkg::mips_instr_u instr_d,
  output logic                  memtoreg_d,
  output logic                  memwrite_d,
  output logic                  alusrc_d,
  output logic                  regdst_d,
  output logic                  regwrite_d,
  output logic                  branch_d,
  output logic                  jump_d,
  output logic                  jal_d,
  output logic                  jr_d,
  output mips_pkg::alu_ctrl_e   alucontrol_d
);
  import mips_pkg::*;

  // ALU decoder result for the R-type group
  alu_ctrl_e rtype_alu;
  logic      rtype_ok;

  always_comb begin
    rtype_ok = 1'b1;
    case (instr_d.r_fmt.funct)
      `MIPS_FN_ADD: rtype_alu = ALU_ADD;
      `MIPS_FN_SUB: rtype_alu = ALU_SUB;
      `MIPS_FN_AND: rtype_alu = ALU_AND;
      `MIPS_FN_OR:  rtype_alu = ALU_OR;
      `MIPS_FN_SLT: rtype_alu = ALU_SLT;
      default: begin
        // jr and anything unknown
        rtype_alu = ALU_ADD;
        rtype_ok  = 1'b0;
      end
    endcase
  end

  // Main decoder, every level low is a bubble
  always_comb begin
    memtoreg_d   = 1'b0;
    memwrite_d   = 1'b0;
    alusrc_d     = 1'b0;
    regdst_d     = 1'b0;
    regwrite_d   = 1'b0;
    branch_d     = 1'b0;
    jump_d       = 1'b0;
    jal_d        = 1'b0;
    jr_d         = 1'b0;
    alucontrol_d = ALU_ADD;
    case (instr_d.r_fmt.op)
      `MIPS_OP_RTYPE: begin
        if (rtype_ok) begin
          regwrite_d   = 1'b1;
          regdst_d     = 1'b1;
          alucontrol_d = rtype_alu;
        end else if (instr_d.r_fmt.funct == `MIPS_FN_JR) begin
          // Register jump, no write
          jump_d = 1'b1;
          jr_d   = 1'b1;
        end
      end
      `MIPS_OP_LW: begin
        regwrite_d = 1'b1;
        alusrc_d   = 1'b1;
        memtoreg_d = 1'b1;
      end
      `MIPS_OP_SW: begin
        memwrite_d = 1'b1;
        alusrc_d   = 1'b1;
      end
      `MIPS_OP_ADDI: begin
        regwrite_d = 1'b1;
        alusrc_d   = 1'b1;
      end
      `MIPS_OP_BEQ: branch_d = 1'b1;
      `MIPS_OP_J:   jump_d   = 1'b1;
      `MIPS_OP_JAL: begin
        // Link written to r31 in writeback
        jump_d     = 1'b1;
        jal_d      = 1'b1;
        regwrite_d = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== rtl/mips_pkg.sv ====
/*
 * MIPS core types
 * Instruction word views and ALU control encoding
 */
`include "mips_defs.svh"

package mips_pkg;

  // One instruction word, three decodings
  typedef union packed {
    // Register format
    struct packed {
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r_fmt;
    // Immediate format
    struct packed {
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i_fmt;
    // Jump format
    struct packed {
      logic [5:0]  op;
      logic [25:0] target;
    } j_fmt;
  } mips_instr_u;

  // ALU operation select
  typedef enum logic [2:0] {
    ALU_AND = `MIPS_ALU_AND,
    ALU_OR  = `MIPS_ALU_OR,
    ALU_ADD = `MIPS_ALU_ADD,
    ALU_SUB = `MIPS_ALU_SUB,
    ALU_SLT = `MIPS_ALU_SLT
  } alu_ctrl_e;

endpackage

// ==== rtl/mips_defs.svh ====
/*
 * MIPS subset definitions
 * Opcodes, funct codes, ALU control codes, reset PC and link register
 */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Primary opcodes
`define MIPS_OP_RTYPE 6'b000000
`define MIPS_OP_LW    6'b100011
`define MIPS_OP_SW    6'b101011
`define MIPS_OP_BEQ   6'b000100
`define MIPS_OP_ADDI  6'b001000
`define MIPS_OP_J     6'b000010
`define MIPS_OP_JAL   6'b000011

// Funct codes of the R-type group
`define MIPS_FN_ADD   6'b100000
`define MIPS_FN_SUB   6'b100010
`define MIPS_FN_AND   6'b100100
`define MIPS_FN_OR    6'b100101
`define MIPS_FN_SLT   6'b101010
`define MIPS_FN_JR    6'b001000

// ALU control encodings
`define MIPS_ALU_AND  3'b000
`define MIPS_ALU_OR   3'b001
`define MIPS_ALU_ADD  3'b010
`define MIPS_ALU_SUB  3'b110
`define MIPS_ALU_SLT  3'b111

// First fetch address and jal destination
`define MIPS_RESET_PC 32'h0000_0000
`define MIPS_LINK_REG 5'd31

`endif
